// ==== all.f ====
hdl/noc_pkg.sv
hdl/input_queue.sv
hdl/route_calc.sv
hdl/credit_counter.sv
hdl/switch_allocator.sv
hdl/output_stage.sv
hdl/noc_router.sv
tb/router_tb.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the router testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/1ns --top-module router_tb -f all.f \
  && sim_out="$(./obj_dir/Vrouter_tb)" \
  && echo "$sim_out" \
  && echo "$sim_out" | grep -qx '>>> PASS' \
  && echo "run.sh: simulation passed" \
  || { echo "run.sh: simulation failed"; exit 1; }

// ==== tb/router_tb.sv ====
module router_tb;

  timeunit 1ns;
  timeprecision 1ns;

  localparam int LOC_X          = 1;
  localparam int LOC_Y          = 2;
  localparam int NUM_ROUTES     = 10;
  localparam int TIMEOUT_CYCLES = 40 * NUM_ROUTES + 200;   // Routing entries dominate the run

  localparam noc_pkg::port_idx_t LOCAL = noc_pkg::port_idx_t'(noc_pkg::PORT_LOCAL);
  localparam noc_pkg::port_idx_t NORTH = noc_pkg::port_idx_t'(noc_pkg::PORT_NORTH);
  localparam noc_pkg::port_idx_t EAST  = noc_pkg::port_idx_t'(noc_pkg::PORT_EAST);
  localparam noc_pkg::port_idx_t SOUTH = noc_pkg::port_idx_t'(noc_pkg::PORT_SOUTH);
  localparam noc_pkg::port_idx_t WEST  = noc_pkg::port_idx_t'(noc_pkg::PORT_WEST);

  typedef struct packed {
    noc_pkg::port_idx_t          src;        // Input the flit enters on
    logic [noc_pkg::COORD_W-1:0] dx;
    logic [noc_pkg::COORD_W-1:0] dy;
    noc_pkg::port_idx_t          exp_port;   // Output by the XY rule
  } route_vec_t;

  // Node at (1,2), X is settled first, then Y
  route_vec_t routes [NUM_ROUTES] = '{
    '{LOCAL, 2'd1, 2'd2, LOCAL},   // Same node
    '{LOCAL, 2'd3, 2'd0, EAST},    // X larger wins over Y
    '{LOCAL, 2'd0, 2'd3, WEST},
    '{NORTH, 2'd1, 2'd3, NORTH},   // Same column, Y larger
    '{NORTH, 2'd1, 2'd0, SOUTH},
    '{EAST,  2'd2, 2'd2, EAST},
    '{SOUTH, 2'd0, 2'd0, WEST},
    '{WEST,  2'd1, 2'd1, SOUTH},
    '{WEST,  2'd1, 2'd2, LOCAL},   // Leaves local pointer on input 4
    '{SOUTH, 2'd2, 2'd3, EAST}
  };

  logic                                    clk;
  logic                                    reset_n;
  noc_pkg::flit_t [noc_pkg::NUM_PORTS-1:0] i_flit;
  noc_pkg::port_req_t                      i_val;
  noc_pkg::port_req_t                      o_credit;
  noc_pkg::flit_t [noc_pkg::NUM_PORTS-1:0] o_flit;
  noc_pkg::port_req_t                      o_val;
  noc_pkg::port_req_t                      i_credit = '0;

  int                   cycle = 0;                          // Edges seen so far
  noc_pkg::flit_t       out_flit [$];                       // Output log, port order per cycle
  noc_pkg::port_idx_t   out_port [$];
  int                   out_cyc  [$];
  int                   in_cyc    [noc_pkg::NUM_PORTS];     // Edge that sampled i_val
  int                   cred_cnt  [noc_pkg::NUM_PORTS];     // o_credit pulses this test
  int                   owed      [noc_pkg::NUM_PORTS];     // Credits the receiver still owes
  noc_pkg::credit_cnt_t up_credit [noc_pkg::NUM_PORTS];     // Upstream sender credits
  noc_pkg::port_req_t   hold = '0;                          // Outputs whose credits are withheld
  int                   errors = 0;
  int                   tests_run = 0;
  int                   tests_failed = 0;

  noc_router #(.LOC_X(LOC_X), .LOC_Y(LOC_Y)) dut (
    .clk      (clk),
    .reset_n  (reset_n),
    .i_flit   (i_flit),
    .i_val    (i_val),
    .o_credit (o_credit),
    .o_flit   (o_flit),
    .o_val    (o_val),
    .i_credit (i_credit)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // -------------------------------------------------------------------------
  // Monitor and downstream receiver model
  // -------------------------------------------------------------------------
  always @(posedge clk) begin
    int pend;
    cycle++;
    for (int q = 0; q < noc_pkg::NUM_PORTS; q++) begin
      if (o_val[q]) begin
        out_flit.push_back(o_flit[q]);
        out_port.push_back(noc_pkg::port_idx_t'(q));
        out_cyc.push_back(cycle);
      end
      if (o_credit[q]) begin
        cred_cnt[q]++;
        up_credit[q] = up_credit[q] + 1'b1;    // Sender gets its slot back
      end
      if (i_val[q]) in_cyc[q] = cycle;
      // One credit per cycle, a cycle after each o_val unless held
      pend = owed[q] + int'(o_val[q]);
      if (!hold[q] && pend > 0) begin
        i_credit[q] <= 1'b1;
        pend--;
      end else begin
        i_credit[q] <= 1'b0;
      end
      owed[q] = pend;
    end
  end

  initial begin
    wait (cycle >= TIMEOUT_CYCLES);
    $display("Run timed out after %0d cycles before all tests finished", cycle);
    $display(">>> FAIL");
    $finish;
  end

  // -------------------------------------------------------------------------
  // Helpers and compare tasks
  // -------------------------------------------------------------------------
  function automatic noc_pkg::credit_cnt_t clamp_count(int n);
    noc_pkg::credit_cnt_t top;
    top = '1;
    if (n < 0 || n > int'(top)) return top;   // Out of range still shows as a mismatch
    return noc_pkg::credit_cnt_t'(n);
  endfunction

  function automatic noc_pkg::flit_t make_flit(noc_pkg::port_idx_t src,
                                               logic [noc_pkg::COORD_W-1:0] dx,
                                               logic [noc_pkg::COORD_W-1:0] dy);
    noc_pkg::flit_t f;
    f.head.dest_x  = dx;
    f.head.dest_y  = dy;
    f.head.payload = noc_pkg::PAYLOAD_W'($urandom);
    f.head.payload[noc_pkg::PAYLOAD_W-1 -: 4] = 4'(src);   // Source tag
    return f;
  endfunction

  function automatic logic credits_ok(noc_pkg::port_req_t mask);
    logic ok;
    ok = 1'b1;
    for (int p = 0; p < noc_pkg::NUM_PORTS; p++) begin
      if (mask[p] && up_credit[p] == '0) ok = 1'b0;
    end
    return ok;
  endfunction

  function automatic int total_credits();
    int sum;
    sum = 0;
    foreach (cred_cnt[p]) sum += cred_cnt[p];
    return sum;
  endfunction

  // One flit per masked input, only when every one of them holds a credit
  task automatic send_flits(input noc_pkg::port_req_t mask,
                            input noc_pkg::flit_t [noc_pkg::NUM_PORTS-1:0] fv);
    logic ready;
    ready = 1'b0;
    while (!ready) begin
      @(negedge clk);
      ready = credits_ok(mask);
      if (!ready) begin
        @(posedge clk);
        i_val <= '0;
      end
    end
    @(posedge clk);
    i_flit <= fv;
    i_val  <= mask;
    for (int p = 0; p < noc_pkg::NUM_PORTS; p++) begin
      if (mask[p]) up_credit[p] = up_credit[p] - 1'b1;
    end
  endtask

  task automatic idle_inputs();
    @(posedge clk);
    i_val <= '0;
  endtask

  task automatic wait_events(input int n);
    while (out_port.size() < n) @(negedge clk);
  endtask

  task automatic clear_log();
    out_flit.delete();
    out_port.delete();
    out_cyc.delete();
    foreach (cred_cnt[p]) cred_cnt[p] = 0;
  endtask

  task automatic check_flit(input string name, input noc_pkg::flit_t got,
                            input noc_pkg::flit_t exp);
    if (got !== exp) begin
      errors++;
      $display("Mismatch %s: got %h, expected %h", name, got.raw, exp.raw);
    end
  endtask

  task automatic check_port(input string name, input noc_pkg::port_idx_t got,
                            input noc_pkg::port_idx_t exp);
    if (got !== exp) begin
      errors++;
      $display("Mismatch %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_count(input string name, input noc_pkg::credit_cnt_t got,
                             input noc_pkg::credit_cnt_t exp);
    if (got !== exp) begin
      errors++;
      $display("Mismatch %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic report_test(input string name, input int err_start);
    tests_run++;
    if (errors == err_start) begin
      $display("Test %s ok", name);
    end else begin
      tests_failed++;
      $display("Test %s failed with %0d errors", name, errors - err_start);
    end
  endtask

  // -------------------------------------------------------------------------
  // Test sequence
  // -------------------------------------------------------------------------
  initial begin
    noc_pkg::flit_t                          f;
    noc_pkg::flit_t [noc_pkg::NUM_PORTS-1:0] fv;
    noc_pkg::flit_t                          exp_q [$];
    noc_pkg::port_req_t                      mask;
    int                                      err_start;

    reset_n = 1'b0;
    i_val   = '0;
    i_flit  = '0;
    foreach (up_credit[p]) up_credit[p] = noc_pkg::credit_cnt_t'(noc_pkg::INPUT_DEPTH);
    void'($urandom(32'h8a9c_c87a));

    // Reset, nothing may leave through reset and the first cycle after
    err_start = errors;
    repeat (8) @(posedge clk);
    reset_n <= 1'b1;
    repeat (2) @(posedge clk);
    @(negedge clk);
    check_count("o_val events", clamp_count(out_port.size()), '0);
    check_count("o_credit events", clamp_count(total_credits()), '0);
    report_test("reset", err_start);

    for (int i = 0; i < NUM_ROUTES; i++) begin
      err_start = errors;
      clear_log();
      f  = make_flit(routes[i].src, routes[i].dx, routes[i].dy);
      fv = '0;
      fv[routes[i].src] = f;
      send_flits(noc_pkg::port_req_t'(1) << routes[i].src, fv);
      idle_inputs();
      wait_events(1);
      repeat (4) @(negedge clk);                 // Window for stray outputs
      check_count("output events", clamp_count(out_port.size()), noc_pkg::credit_cnt_t'(1));
      check_port("output port", out_port[0], routes[i].exp_port);
      check_flit("o_flit", out_flit[0], f);
      check_count("o_val latency", clamp_count(out_cyc[0] - in_cyc[routes[i].src]),
                  noc_pkg::credit_cnt_t'(2));
      check_count("o_credit", clamp_count(cred_cnt[routes[i].src]), noc_pkg::credit_cnt_t'(1));
      check_count("o_credit total", clamp_count(total_credits()), noc_pkg::credit_cnt_t'(1));
      report_test($sformatf("route %0d", i), err_start);
    end

    // East receiver stops returning credits, west input sends six
    err_start = errors;
    clear_log();
    exp_q.delete();
    hold[noc_pkg::PORT_EAST] = 1'b1;
    for (int i = 0; i < 6; i++) begin
      fv = '0;
      fv[noc_pkg::PORT_WEST] = make_flit(WEST, 2'd3, 2'd2);
      exp_q.push_back(fv[noc_pkg::PORT_WEST]);
      send_flits(noc_pkg::port_req_t'(1) << noc_pkg::PORT_WEST, fv);
    end
    idle_inputs();
    wait_events(noc_pkg::DOWNSTREAM_DEPTH);
    repeat (10) @(negedge clk);
    check_count("east outputs while held", clamp_count(out_port.size()),
                noc_pkg::credit_cnt_t'(noc_pkg::DOWNSTREAM_DEPTH));
    hold[noc_pkg::PORT_EAST] = 1'b0;           // Owed credits trickle back
    wait_events(6);
    repeat (4) @(negedge clk);
    check_count("east outputs", clamp_count(out_port.size()), noc_pkg::credit_cnt_t'(6));
    foreach (exp_q[i]) begin
      check_port("output port", out_port[i], EAST);
      check_flit("o_flit", out_flit[i], exp_q[i]);
    end
    check_count("o_credit west", clamp_count(cred_cnt[noc_pkg::PORT_WEST]),
                noc_pkg::credit_cnt_t'(6));
    report_test("backpressure", err_start);

    // North and south both target local in the same cycles
    err_start = errors;
    clear_log();
    exp_q.delete();
    mask = '0;
    mask[noc_pkg::PORT_NORTH] = 1'b1;
    mask[noc_pkg::PORT_SOUTH] = 1'b1;
    for (int i = 0; i < 4; i++) begin
      fv = '0;
      fv[noc_pkg::PORT_NORTH] = make_flit(NORTH, 2'd1, 2'd2);
      fv[noc_pkg::PORT_SOUTH] = make_flit(SOUTH, 2'd1, 2'd2);
      exp_q.push_back(fv[noc_pkg::PORT_NORTH]);   // North is first after the pointer wraps
      exp_q.push_back(fv[noc_pkg::PORT_SOUTH]);
      send_flits(mask, fv);
    end
    idle_inputs();
    wait_events(8);
    repeat (4) @(negedge clk);
    // Eight flits exceed the count type, so compare the surplus over the expected list
    check_count("local outputs over expected",
                clamp_count(out_port.size() - exp_q.size()), '0);
    foreach (exp_q[i]) begin
      check_port("output port", out_port[i], LOCAL);
      check_flit("o_flit", out_flit[i], exp_q[i]);
    end
    check_count("o_credit north", clamp_count(cred_cnt[noc_pkg::PORT_NORTH]),
                noc_pkg::credit_cnt_t'(4));
    check_count("o_credit south", clamp_count(cred_cnt[noc_pkg::PORT_SOUTH]),
                noc_pkg::credit_cnt_t'(4));
    report_test("round robin", err_start);

    // Every flit sent over the run came back as one credit
    err_start = errors;
    foreach (up_credit[p]) begin
      check_count($sformatf("upstream credits of input %0d", p), up_credit[p],
                  noc_pkg::credit_cnt_t'(noc_pkg::INPUT_DEPTH));
    end
    report_test("credit balance", err_start);

    $display("Tests run %0d, failed %0d, check errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// ==== hdl/noc_router.sv ====
module noc_router #(
  parameter int LOC_X = 0,      // Node column in the mesh
  parameter int LOC_Y = 0       // Node row in the mesh
) (
  input  logic                                        clk,
  input  logic                                        reset_n,

  // Upstream side, one entry per input port
  input  noc_pkg::flit_t     [noc_pkg::NUM_PORTS-1:0] i_flit,
  input  noc_pkg::port_req_t                          i_val,
  output noc_pkg::port_req_t                          o_credit,   // Slot freed in input queue

  // Downstream side, one entry per output port
  output noc_pkg::flit_t     [noc_pkg::NUM_PORTS-1:0] o_flit,
  output noc_pkg::port_req_t                          o_val,
  input  noc_pkg::port_req_t                          i_credit    // Slot freed downstream
);

  noc_pkg::flit_t     [noc_pkg::NUM_PORTS-1:0] head_flit;   // Queue heads
  noc_pkg::port_req_t                          head_val;
  noc_pkg::port_req_t [noc_pkg::NUM_PORTS-1:0] req;         // Route request per input
  noc_pkg::port_req_t [noc_pkg::NUM_PORTS-1:0] grant;       // Grant word per output
  noc_pkg::port_req_t                          pop;
  noc_pkg::port_req_t                          send;
  noc_pkg::port_req_t                          has_credit;

  // -------------------------------------------------------------------------
  // Input side, queue and route per port
  // -------------------------------------------------------------------------
  for (genvar p = 0; p < noc_pkg::NUM_PORTS; p++) begin : g_in
    input_queue u_queue (
      .clk         (clk),
      .reset_n     (reset_n),
      .i_flit      (i_flit[p]),
      .i_val       (i_val[p]),
      .i_pop       (pop[p]),          // From allocator
      .o_head_flit (head_flit[p]),
      .o_head_val  (head_val[p]),
      .o_credit    (o_credit[p])      // Back to upstream sender
    );

    route_calc #(.LOC_X(LOC_X), .LOC_Y(LOC_Y)) u_route (
      .i_head_flit (head_flit[p]),
      .i_head_val  (head_val[p]),
      .o_req       (req[p])
    );
  end

  // Downstream credit tracking per output
  for (genvar q = 0; q < noc_pkg::NUM_PORTS; q++) begin : g_out
    credit_counter u_credit (
      .clk          (clk),
      .reset_n      (reset_n),
      .i_send       (send[q]),
      .i_credit     (i_credit[q]),
      .o_has_credit (has_credit[q])
    );
  end

  // -------------------------------------------------------------------------
  // Allocation and switch traversal
  // -------------------------------------------------------------------------
  switch_allocator u_alloc (
    .clk          (clk),
    .reset_n      (reset_n),
    .i_req        (req),
    .i_has_credit (has_credit),
    .o_grant      (grant),
    .o_pop        (pop),
    .o_send       (send)
  );

  output_stage u_out (
    .clk         (clk),
    .reset_n     (reset_n),
    .i_head_flit (head_flit),
    .i_grant     (grant),
    .o_flit      (o_flit),
    .o_val       (o_val)
  );

endmodule

// ==== hdl/output_stage.sv ====
module output_stage (
  input  logic                                        clk,
  input  logic                                        reset_n,
  input  noc_pkg::flit_t     [noc_pkg::NUM_PORTS-1:0] i_head_flit,  // Queue heads
  input  noc_pkg::port_req_t [noc_pkg::NUM_PORTS-1:0] i_grant,      // One-hot over inputs
  output noc_pkg::flit_t     [noc_pkg::NUM_PORTS-1:0] o_flit,       // To downstream nodes
  output noc_pkg::port_req_t                          o_val
);

  noc_pkg::flit_t [noc_pkg::NUM_PORTS-1:0] sel_flit;   // Crossbar outputs

  // -------------------------------------------------------------------------
  // One-hot crossbar as an AND-OR mux
  // -------------------------------------------------------------------------
  always_comb begin
    sel_flit = '0;
    for (int q = 0; q < noc_pkg::NUM_PORTS; q++) begin
      for (int p = 0; p < noc_pkg::NUM_PORTS; p++) begin
        sel_flit[q].raw = sel_flit[q].raw |
                          ({noc_pkg::FLIT_W{i_grant[q][p]}} & i_head_flit[p].raw);
      end
    end
  end

  // Output data registers, loaded only on a grant
  always_ff @(posedge clk) begin
    for (int q = 0; q < noc_pkg::NUM_PORTS; q++) begin
      if (|i_grant[q]) begin
        o_flit[q].raw <= sel_flit[q].raw;
      end
    end
  end

  // Valid follows the grant by one cycle
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      o_val <= '0;
    end else begin
      for (int q = 0; q < noc_pkg::NUM_PORTS; q++) begin
        o_val[q] <= |i_grant[q];
      end
    end
  end

endmodule

// ==== hdl/switch_allocator.sv ====
module switch_allocator (
  input  logic                                        clk,
  input  logic                                        reset_n,
  input  noc_pkg::port_req_t [noc_pkg::NUM_PORTS-1:0] i_req,         // Per input, over outputs
  input  noc_pkg::port_req_t                          i_has_credit,  // Per output
  output noc_pkg::port_req_t [noc_pkg::NUM_PORTS-1:0] o_grant,       // Per output, over inputs
  output noc_pkg::port_req_t                          o_pop,         // Per input
  output noc_pkg::port_req_t                          o_send         // Per output
);

  noc_pkg::port_req_t [noc_pkg::NUM_PORTS-1:0] out_req;    // Requesters of each output
  noc_pkg::port_idx_t [noc_pkg::NUM_PORTS-1:0] last_gnt;   // Round-robin pointer per output
  noc_pkg::port_idx_t [noc_pkg::NUM_PORTS-1:0] gnt_idx;    // Input granted this cycle

  // -------------------------------------------------------------------------
  // Transpose input requests into per-output requester sets
  // -------------------------------------------------------------------------
  always_comb begin
    for (int q = 0; q < noc_pkg::NUM_PORTS; q++) begin
      for (int p = 0; p < noc_pkg::NUM_PORTS; p++) begin
        out_req[q][p] = i_req[p][q];
      end
    end
  end

  // -------------------------------------------------------------------------
  // Round-robin search per output
  // -------------------------------------------------------------------------
  always_comb begin
    int   idx;
    logic found;

    o_grant = '0;
    gnt_idx = '0;
    for (int q = 0; q < noc_pkg::NUM_PORTS; q++) begin
      found = 1'b0;
      // Start one past the last winner, wrap around all inputs
      for (int off = 1; off <= noc_pkg::NUM_PORTS; off++) begin
        idx = (int'(last_gnt[q]) + off) % noc_pkg::NUM_PORTS;
        if (!found && i_has_credit[q] && out_req[q][idx]) begin
          o_grant[q][idx] = 1'b1;
          gnt_idx[q]      = noc_pkg::port_idx_t'(idx);
          found           = 1'b1;
        end
      end
    end
  end

  // Each input asks for one output only, so at most one grant per input
  always_comb begin
    o_pop = '0;
    for (int q = 0; q < noc_pkg::NUM_PORTS; q++) begin
      o_pop     = o_pop | o_grant[q];   // Head leaves its queue
      o_send[q] = |o_grant[q];          // Output consumes a credit
    end
  end

  // -------------------------------------------------------------------------
  // Pointer state
  // -------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      for (int q = 0; q < noc_pkg::NUM_PORTS; q++) begin
        // Last winner is the top input, so input 0 searches first
        last_gnt[q] <= noc_pkg::port_idx_t'(noc_pkg::NUM_PORTS - 1);
      end
    end else begin
      for (int q = 0; q < noc_pkg::NUM_PORTS; q++) begin
        if (o_send[q]) begin
          last_gnt[q] <= gnt_idx[q];      // Winner drops to lowest priority
        end
      end
    end
  end

endmodule

// ==== hdl/credit_counter.sv ====
module credit_counter (
  input  logic clk,
  input  logic reset_n,
  input  logic i_send,        // Flit leaves on this output
  input  logic i_credit,      // Downstream freed one slot
  output logic o_has_credit   // At least one free slot downstream
);

  noc_pkg::credit_cnt_t count;  // Free slots at the receiver

  // -------------------------------------------------------------------------
  // Credit count
  // -------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      count <= noc_pkg::credit_cnt_t'(noc_pkg::DOWNSTREAM_DEPTH);  // Receiver starts empty
    end else begin
      case ({i_send, i_credit})
        2'b10:   count <= count - 1'b1;   // Slot consumed
        2'b01:   count <= count + 1'b1;   // Slot returned
        default: count <= count;          // Both cancel out
      endcase
    end
  end

  // Allocator only sends while this is high, so no underflow
  assign o_has_credit = (count != '0);

endmodule

// ==== hdl/route_calc.sv ====
module route_calc #(
  parameter int LOC_X = 0,              // Column of this node
  parameter int LOC_Y = 0               // Row of this node
) (
  input  noc_pkg::flit_t     i_head_flit,
  input  logic               i_head_val,
  output noc_pkg::port_req_t o_req      // One-hot output request
);

  logic [noc_pkg::COORD_W-1:0] loc_x;
  logic [noc_pkg::COORD_W-1:0] loc_y;
  logic [noc_pkg::COORD_W-1:0] dest_x;
  logic [noc_pkg::COORD_W-1:0] dest_y;

  assign loc_x  = LOC_X[noc_pkg::COORD_W-1:0];
  assign loc_y  = LOC_Y[noc_pkg::COORD_W-1:0];
  assign dest_x = i_head_flit.head.dest_x;
  assign dest_y = i_head_flit.head.dest_y;

  // -------------------------------------------------------------------------
  // XY dimension order, X is resolved before Y
  // -------------------------------------------------------------------------
  always_comb begin
    o_req = '0;
    if (i_head_val) begin
      if (dest_x > loc_x) begin
        o_req[noc_pkg::PORT_EAST] = 1'b1;
      end else if (dest_x < loc_x) begin
        o_req[noc_pkg::PORT_WEST] = 1'b1;
      end else if (dest_y > loc_y) begin
        o_req[noc_pkg::PORT_NORTH] = 1'b1;   // Same column, go up
      end else if (dest_y < loc_y) begin
        o_req[noc_pkg::PORT_SOUTH] = 1'b1;
      end else begin
        o_req[noc_pkg::PORT_LOCAL] = 1'b1;   // Arrived
      end
    end
  end

endmodule

// ==== hdl/input_queue.sv ====
module input_queue (
  input  logic           clk,
  input  logic           reset_n,
  input  noc_pkg::flit_t i_flit,       // From upstream sender
  input  logic           i_val,        // Sender holds a credit when high
  input  logic           i_pop,        // Head is granted this cycle
  output noc_pkg::flit_t o_head_flit,  // Oldest stored flit
  output logic           o_head_val,
  output logic           o_credit      // One pulse per flit removed
);

  noc_pkg::flit_t              mem [noc_pkg::INPUT_DEPTH];  // Flit storage
  logic [noc_pkg::QPTR_W-1:0]  wr_ptr;
  logic [noc_pkg::QPTR_W-1:0]  rd_ptr;
  logic [noc_pkg::QCNT_W-1:0]  count;   // Occupancy
  logic                        wr_en;
  logic                        rd_en;

  assign wr_en = i_val && (count != noc_pkg::QUEUE_FULL);  // Full queue never takes a flit
  assign rd_en = i_pop && o_head_val;                      // Ignore pop on empty queue

  // -------------------------------------------------------------------------
  // Storage
  // -------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= i_flit;
    end
  end

  assign o_head_flit = mem[rd_ptr];      // Visible the cycle after the write
  assign o_head_val  = (count != '0);

  // -------------------------------------------------------------------------
  // Pointers, occupancy and credit return
  // -------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      o_credit <= 1'b0;
    end else begin
      if (wr_en) begin
        wr_ptr <= (wr_ptr == noc_pkg::QPTR_LAST) ? '0 : wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= (rd_ptr == noc_pkg::QPTR_LAST) ? '0 : rd_ptr + 1'b1;
      end

      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;        // Idle or write and read together
      endcase

      o_credit <= rd_en;                // Slot freed, hand it back upstream
    end
  end

endmodule

// ==== hdl/noc_pkg.sv ====
package noc_pkg;

  // -------------------------------------------------------------------------
  // Router ports and mesh geometry
  // -------------------------------------------------------------------------
  localparam int NUM_PORTS  = 5;
  localparam int PORT_LOCAL = 0;          // Attached core
  localparam int PORT_NORTH = 1;          // Towards increasing Y
  localparam int PORT_EAST  = 2;          // Towards increasing X
  localparam int PORT_SOUTH = 3;
  localparam int PORT_WEST  = 4;

  localparam int MESH_DIM   = 4;          // Nodes per axis
  localparam int COORD_W    = $clog2(MESH_DIM);
  localparam int FLIT_W     = 32;
  localparam int PAYLOAD_W  = FLIT_W - 2 * COORD_W;

  // -------------------------------------------------------------------------
  // Buffering and flow control
  // -------------------------------------------------------------------------
  localparam int INPUT_DEPTH      = 4;    // Also initial upstream credits
  localparam int DOWNSTREAM_DEPTH = 4;    // Credits per output after reset

  localparam int QPTR_W     = $clog2(INPUT_DEPTH);
  localparam int QCNT_W     = $clog2(INPUT_DEPTH + 1);
  localparam int CREDIT_W   = $clog2(DOWNSTREAM_DEPTH + 1);
  localparam int PORT_IDX_W = $clog2(NUM_PORTS);

  localparam logic [QCNT_W-1:0] QUEUE_FULL = QCNT_W'(INPUT_DEPTH);    // Occupancy when full
  localparam logic [QPTR_W-1:0] QPTR_LAST  = QPTR_W'(INPUT_DEPTH - 1); // Wrap point

  typedef logic [NUM_PORTS-1:0]  port_req_t;    // One bit per port
  typedef logic [CREDIT_W-1:0]   credit_cnt_t;
  typedef logic [PORT_IDX_W-1:0] port_idx_t;

  // Single-flit packet
  // Route logic decodes the head view, datapath moves the raw word
  typedef union packed {
    struct packed {
      logic [COORD_W-1:0]   dest_x;     // Upper bits
      logic [COORD_W-1:0]   dest_y;
      logic [PAYLOAD_W-1:0] payload;
    } head;
    logic [FLIT_W-1:0] raw;
  } flit_t;

endpackage
